// ==== hw/mm2s_pkg.sv ====
// Bus geometry, transfer-size encoding and byte-lane helper functions
package mm2s_pkg;

	// Fixed 32-bit data bus
	localparam int BUS_BYTES = 4;
	// Address bits that pick a byte inside a word
	localparam int WBLSB = 2;

	// Transfer size of each bus access
	// Code 01 is also taken as a full word
	typedef enum logic [1:0] {
		SZ_WORD = 2'b00,
		SZ_HALF = 2'b10,
		SZ_BYTE = 2'b11
	} xfer_size_e;

	// Big-endian lane mask
	// Byte 0 of the word sits on the MSB lane
	function automatic logic [BUS_BYTES-1:0] be_select(
		input logic [WBLSB:0]   nbytes,
		input logic [WBLSB-1:0] offset
	);
		logic [BUS_BYTES-1:0] lead;
		// Left-justified run of nbytes ones
		lead = ~({BUS_BYTES{1'b1}} >> nbytes);
		return lead >> offset;
	endfunction

	// Size of the following access
	// Bytes left must already be capped at one word
	function automatic logic [WBLSB:0] step_size(
		input xfer_size_e     size,
		input logic [WBLSB:0] left
	);
		logic [WBLSB:0] half;
		half = (left < (WBLSB+1)'(2)) ? left : (WBLSB+1)'(2);
		case (size)
		SZ_BYTE: return (WBLSB+1)'(1);
		SZ_HALF: return half;
		default: return left;
		endcase
	endfunction

endpackage

// ==== hw/mm2s_request_decode.sv ====
// Request capture, busy and error FSM, first-access size and lane select
module mm2s_request_decode
	import mm2s_pkg::*;
#(
	parameter int ADDRESS_WIDTH = 16,
	parameter int LGLENGTH      = 8
) (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_request,
	input  xfer_size_e               i_size,
	input  logic [ADDRESS_WIDTH-1:0] i_addr,
	input  logic [LGLENGTH:0]        i_transferlen,
	input  logic                     i_bus_fail,
	input  logic                     i_stream_done,
	output logic                     o_busy,
	output logic                     o_err,
	output logic                     o_start,
	output xfer_size_e               o_cfg_size,
	output logic [WBLSB:0]           o_first_size,
	output logic [BUS_BYTES-1:0]     o_first_sel
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_FAULT
	} state_e;

	state_e           state;
	logic [WBLSB-1:0] offset;
	// Bytes up to the end of the first access unit
	logic [WBLSB:0]   span;

	assign offset  = i_addr[WBLSB-1:0];
	assign o_busy  = (state == ST_BUSY);
	assign o_err   = (state == ST_FAULT);
	// Request taken
	assign o_start = i_request && !o_busy;

	////////////////////////////////////////////////////////////////////////////
	// Transfer state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			state <= ST_IDLE;
		else
		begin
			case (state)
			ST_BUSY:
			begin
				// Bus error wins over completion
				if (i_bus_fail)
					state <= ST_FAULT;
				else if (i_stream_done)
					state <= ST_IDLE;
			end
			default:
			begin
				// Fault level holds until the next request
				if (i_request)
					state <= ST_BUSY;
			end
			endcase
		end
	end

	// Size held for the whole transfer
	always_ff @(posedge i_clk)
	begin
		if (o_start)
			o_cfg_size <= i_size;
	end

	////////////////////////////////////////////////////////////////////////////
	// First access
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (i_size)
		SZ_BYTE: span = (WBLSB+1)'(1);
		SZ_HALF: span = offset[0] ? (WBLSB+1)'(1) : (WBLSB+1)'(2);
		default: span = (WBLSB+1)'(BUS_BYTES) - (WBLSB+1)'(offset);
		endcase
		// Short transfer ends inside the first unit
		if ((LGLENGTH+1)'(span) > i_transferlen)
			o_first_size = i_transferlen[WBLSB:0];
		else
			o_first_size = span;
	end

	assign o_first_sel = be_select(o_first_size, offset);

	// Other stages only report events during a transfer
	a_events_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_bus_fail || i_stream_done) |-> o_busy);

endmodule

// ==== hw/mm2s_bus_reader.sv ====
// Pipelined read strobes, address and select stepping, outstanding count, error abort
module mm2s_bus_reader
	import mm2s_pkg::*;
#(
	parameter int ADDRESS_WIDTH = 16,
	parameter int LGLENGTH      = 8
) (
	input  logic                           i_clk,
	input  logic                           i_reset,
	input  logic                           i_start,
	input  logic [ADDRESS_WIDTH-1:0]       i_addr,
	input  logic [LGLENGTH:0]              i_transferlen,
	input  xfer_size_e                     i_cfg_size,
	input  logic [WBLSB:0]                 i_first_size,
	input  logic [BUS_BYTES-1:0]           i_first_sel,
	input  logic                           i_rd_stall,
	input  logic                           i_rd_ack,
	input  logic                           i_rd_err,
	output logic                           o_rd_cyc,
	output logic                           o_rd_stb,
	output logic [ADDRESS_WIDTH-WBLSB-1:0] o_rd_addr,
	output logic [BUS_BYTES-1:0]           o_rd_sel,
	output logic                           o_bus_fail
);

	// Byte address of the current strobe
	logic [ADDRESS_WIDTH-1:0] stb_addr;
	logic [ADDRESS_WIDTH-1:0] next_addr;
	// Bytes not yet covered by an accepted strobe
	logic [LGLENGTH:0]        stb_len;
	logic [LGLENGTH:0]        stb_left;
	logic [WBLSB:0]           stb_size;
	logic [WBLSB:0]           left_sat;
	logic [WBLSB:0]           next_size;
	logic [BUS_BYTES-1:0]     next_sel;
	logic [LGLENGTH:0]        outstanding;
	logic                     accept;
	logic                     more;

	assign accept     = o_rd_stb && !i_rd_stall;
	assign o_bus_fail = o_rd_cyc && i_rd_err;
	assign o_rd_addr  = stb_addr[ADDRESS_WIDTH-1:WBLSB];

	////////////////////////////////////////////////////////////////////////////
	// Next strobe
	////////////////////////////////////////////////////////////////////////////

	// Another strobe follows this one
	assign more     = stb_len > (LGLENGTH+1)'(stb_size);
	assign stb_left = more ? stb_len - (LGLENGTH+1)'(stb_size) : '0;
	// Capped at one word
	assign left_sat = (stb_left >= (LGLENGTH+1)'(BUS_BYTES))
		? (WBLSB+1)'(BUS_BYTES) : stb_left[WBLSB:0];

	assign next_size = step_size(i_cfg_size, left_sat);
	assign next_addr = stb_addr + ADDRESS_WIDTH'(stb_size);
	assign next_sel  = be_select(next_size, next_addr[WBLSB-1:0]);

	////////////////////////////////////////////////////////////////////////////
	// Cycle and strobe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || o_bus_fail)
		begin
			o_rd_cyc <= 1'b0;
			o_rd_stb <= 1'b0;
		end
		else if (i_start)
		begin
			o_rd_cyc <= 1'b1;
			o_rd_stb <= 1'b1;
		end
		else if (o_rd_cyc)
		begin
			// Strobe stays up until the final one goes out
			if (accept && !more)
				o_rd_stb <= 1'b0;
			// Strobes done and final ack back
			if (!o_rd_stb && outstanding == (LGLENGTH+1)'(i_rd_ack))
				o_rd_cyc <= 1'b0;
		end
	end

	// Address, length and lanes only move on an accepted strobe
	always_ff @(posedge i_clk)
	begin
		if (i_start)
		begin
			stb_addr <= i_addr;
			stb_len  <= i_transferlen;
			stb_size <= i_first_size;
			o_rd_sel <= i_first_sel;
		end
		else if (accept)
		begin
			stb_addr <= next_addr;
			stb_len  <= stb_left;
			stb_size <= next_size;
			o_rd_sel <= next_sel;
		end
	end

	// Reads in flight
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !o_rd_cyc || i_rd_err)
			outstanding <= '0;
		else
		begin
			case ({accept, i_rd_ack})
			2'b10: outstanding <= outstanding + 1'b1;
			2'b01: outstanding <= outstanding - 1'b1;
			default: ;
			endcase
		end
	end

	// Lanes from decode and from stepping are never empty
	a_sel_live: assert property (@(posedge i_clk) disable iff (i_reset)
		o_rd_stb |-> (o_rd_sel != '0));

	// Slave never acks a read that was not issued
	a_no_underflow: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_rd_cyc && i_rd_ack) |-> (outstanding != '0));

endmodule

// ==== hw/mm2s_stream_packer.sv ====
// Return tracking, fill level, realignment shift register and stream beats
module mm2s_stream_packer
	import mm2s_pkg::*;
#(
	parameter int LGLENGTH = 8
) (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_start,
	input  logic                   i_busy,
	input  logic [WBLSB-1:0]       i_addr,
	input  logic [LGLENGTH:0]      i_transferlen,
	input  xfer_size_e             i_cfg_size,
	input  logic [WBLSB:0]         i_first_size,
	input  logic                   i_rd_ack,
	input  logic [8*BUS_BYTES-1:0] i_rd_data,
	output logic                   o_m_valid,
	output logic [8*BUS_BYTES-1:0] o_m_data,
	output logic [WBLSB:0]         o_m_bytes,
	output logic                   o_m_last,
	output logic                   o_stream_done
);

	localparam int DW = 8 * BUS_BYTES;

	// Bytes still to come back from the bus
	logic [LGLENGTH:0]  ack_len;
	logic [LGLENGTH:0]  ack_left;
	// Size and lane offset of the next return
	logic [WBLSB:0]     ack_size;
	logic [WBLSB-1:0]   pre_shift;
	logic [WBLSB:0]     left_sat;
	logic [WBLSB:0]     next_size;
	logic               final_ack;
	// Bytes held in sreg, including those on the current beat
	logic [WBLSB+1:0]   fill;
	logic [WBLSB+1:0]   base;
	logic [WBLSB+1:0]   next_fill;
	logic [WBLSB:0]     consumed;
	logic [WBLSB:0]     beat_bytes;
	logic               len_done;
	logic [DW-1:0]      keep_mask;
	logic [DW-1:0]      shifted;
	logic [2*DW-1:0]    sreg;
	logic [2*DW-1:0]    kept;
	logic [2*DW-1:0]    merged;

	////////////////////////////////////////////////////////////////////////////
	// Return tracking
	////////////////////////////////////////////////////////////////////////////

	assign final_ack = ack_len <= (LGLENGTH+1)'(ack_size);
	assign ack_left  = final_ack ? '0 : ack_len - (LGLENGTH+1)'(ack_size);
	assign left_sat  = (ack_left >= (LGLENGTH+1)'(BUS_BYTES))
		? (WBLSB+1)'(BUS_BYTES) : ack_left[WBLSB:0];
	assign next_size = step_size(i_cfg_size, left_sat);

	// Same stepping as the strobes, one return at a time
	always_ff @(posedge i_clk)
	begin
		if (i_start)
		begin
			ack_len   <= i_transferlen;
			ack_size  <= i_first_size;
			pre_shift <= i_addr;
		end
		else if (i_rd_ack)
		begin
			ack_len   <= ack_left;
			ack_size  <= next_size;
			// Offset wraps within the word
			pre_shift <= pre_shift + ack_size[WBLSB-1:0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Realignment
	////////////////////////////////////////////////////////////////////////////

	// Wanted bytes moved to the top, unselected lanes cleared
	assign keep_mask = ~({DW{1'b1}} >> (8 * ack_size));
	assign shifted   = (i_rd_data << (8 * pre_shift)) & keep_mask;

	// Current beat leaves sreg at the end of this cycle
	assign consumed  = o_m_valid ? o_m_bytes : '0;
	assign base      = fill - (WBLSB+2)'(consumed);
	assign next_fill = i_rd_ack ? base + (WBLSB+2)'(ack_size) : base;
	assign kept      = sreg << (8 * consumed);
	// New bytes land just below what is left
	assign merged    = {shifted, {DW{1'b0}}} >> (8 * base);

	always_ff @(posedge i_clk)
	begin
		if (i_start)
			sreg <= '0;
		else if (i_busy)
			sreg <= kept | (i_rd_ack ? merged : '0);
	end

	////////////////////////////////////////////////////////////////////////////
	// Stream beats
	////////////////////////////////////////////////////////////////////////////

	assign beat_bytes = (next_fill >= (WBLSB+2)'(BUS_BYTES))
		? (WBLSB+1)'(BUS_BYTES) : next_fill[WBLSB:0];
	// Nothing more to come after this cycle
	assign len_done   = i_rd_ack ? final_ack : (ack_len == '0);

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_busy)
		begin
			fill      <= '0;
			o_m_valid <= 1'b0;
			o_m_bytes <= '0;
			o_m_last  <= 1'b0;
		end
		else
		begin
			fill      <= next_fill;
			// Beat after each ack, then one drain beat for leftovers
			o_m_valid <= i_rd_ack || (ack_len == '0 && base != '0);
			o_m_bytes <= beat_bytes;
			o_m_last  <= len_done && (next_fill <= (WBLSB+2)'(BUS_BYTES));
		end
	end

	assign o_m_data      = sreg[2*DW-1:DW];
	assign o_stream_done = o_m_valid && o_m_last;

	// Every beat carries at least one byte and at most a word
	a_beat_bytes: assert property (@(posedge i_clk) disable iff (i_reset)
		o_m_valid |-> (o_m_bytes != '0 && o_m_bytes <= (WBLSB+1)'(BUS_BYTES)));

	// Nothing follows the last beat of a transfer
	a_last_alone: assert property (@(posedge i_clk) disable iff (i_reset)
		o_stream_done |=> !o_m_valid);

endmodule

// ==== hw/mm2s_top.sv ====
// DMA reader top level with request decode, bus reader and stream packer
module mm2s_top
	import mm2s_pkg::*;
#(
	parameter int ADDRESS_WIDTH = 16,
	parameter int LGLENGTH      = 8
) (
	input  logic                           i_clk,
	input  logic                           i_reset,
	// Request
	input  logic                           i_request,
	input  xfer_size_e                     i_size,
	input  logic [ADDRESS_WIDTH-1:0]       i_addr,
	input  logic [LGLENGTH:0]              i_transferlen,
	output logic                           o_busy,
	output logic                           o_err,
	// Wishbone read master
	output logic                           o_rd_cyc,
	output logic                           o_rd_stb,
	output logic [ADDRESS_WIDTH-WBLSB-1:0] o_rd_addr,
	output logic [BUS_BYTES-1:0]           o_rd_sel,
	input  logic                           i_rd_stall,
	input  logic                           i_rd_ack,
	input  logic [8*BUS_BYTES-1:0]         i_rd_data,
	input  logic                           i_rd_err,
	// Outgoing byte stream
	output logic                           o_m_valid,
	output logic [8*BUS_BYTES-1:0]         o_m_data,
	output logic [WBLSB:0]                 o_m_bytes,
	output logic                           o_m_last
);

	logic                 start;
	xfer_size_e           cfg_size;
	logic [WBLSB:0]       first_size;
	logic [BUS_BYTES-1:0] first_sel;
	logic                 bus_fail;
	logic                 stream_done;

	// Configuration and transfer state
	mm2s_request_decode #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.LGLENGTH(LGLENGTH)
	) u_decode (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_size(i_size),
		.i_addr(i_addr),
		.i_transferlen(i_transferlen),
		.i_bus_fail(bus_fail),
		.i_stream_done(stream_done),
		.o_busy(o_busy),
		.o_err(o_err),
		.o_start(start),
		.o_cfg_size(cfg_size),
		.o_first_size(first_size),
		.o_first_sel(first_sel)
	);

	// Execute stage
	mm2s_bus_reader #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.LGLENGTH(LGLENGTH)
	) u_reader (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_start(start),
		.i_addr(i_addr),
		.i_transferlen(i_transferlen),
		.i_cfg_size(cfg_size),
		.i_first_size(first_size),
		.i_first_sel(first_sel),
		.i_rd_stall(i_rd_stall),
		.i_rd_ack(i_rd_ack),
		.i_rd_err(i_rd_err),
		.o_rd_cyc(o_rd_cyc),
		.o_rd_stb(o_rd_stb),
		.o_rd_addr(o_rd_addr),
		.o_rd_sel(o_rd_sel),
		.o_bus_fail(bus_fail)
	);

	// Result stage only needs the byte offset of the start address
	mm2s_stream_packer #(
		.LGLENGTH(LGLENGTH)
	) u_packer (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_start(start),
		.i_busy(o_busy),
		.i_addr(i_addr[WBLSB-1:0]),
		.i_transferlen(i_transferlen),
		.i_cfg_size(cfg_size),
		.i_first_size(first_size),
		.i_rd_ack(i_rd_ack),
		.i_rd_data(i_rd_data),
		.o_m_valid(o_m_valid),
		.o_m_data(o_m_data),
		.o_m_bytes(o_m_bytes),
		.o_m_last(o_m_last),
		.o_stream_done(stream_done)
	);

endmodule

// ==== tests/mm2s_mem_model.sv ====
// Wishbone pipelined read slave with random stall, random ack delay and error injection
module mm2s_mem_model
	import mm2s_pkg::*;
#(
	parameter int ADDRESS_WIDTH = 16
) (
	input  logic                           i_clk,
	input  logic                           i_cyc,
	input  logic                           i_stb,
	input  logic [ADDRESS_WIDTH-WBLSB-1:0] i_addr,
	input  int                             i_err_index,
	output logic                           o_stall,
	output logic                           o_ack,
	output logic                           o_err,
	output logic [8*BUS_BYTES-1:0]         o_data
);
	timeunit 1ns;
	timeprecision 1ps;

	integer                         seed;
	int                             cycle;
	// Strobes accepted in the current bus cycle
	int                             strobe_count;
	// Pending reads, in order of acceptance
	int                             ready_q[$];
	logic [ADDRESS_WIDTH-WBLSB-1:0] addr_q[$];
	bit                             fail_q[$];

	// Byte a holds a folded to eight bits XOR 5a, byte 0 on the MSB lane
	function automatic logic [8*BUS_BYTES-1:0] word_at(
		input logic [ADDRESS_WIDTH-WBLSB-1:0] waddr
	);
		logic [ADDRESS_WIDTH-1:0]   base;
		logic [ADDRESS_WIDTH-1:0]   addr;
		logic [7:0]                 value;
		logic [8*BUS_BYTES-1:0]     word;
		base = {waddr, WBLSB'(0)};
		word = '0;
		for (int k = 0; k < BUS_BYTES; k++)
		begin
			addr  = base + ADDRESS_WIDTH'(k);
			value = 8'h5a;
			for (int b = 0; b < ADDRESS_WIDTH; b += 8)
				value = value ^ 8'(addr >> b);
			word[8*(BUS_BYTES-1-k) +: 8] = value;
		end
		return word;
	endfunction

	initial
	begin
		seed         = 32'h1e8b_acec;
		cycle        = 0;
		strobe_count = 0;
		o_stall      = 1'b0;
		o_ack        = 1'b0;
		o_err        = 1'b0;
		o_data       = '0;
	end

	// Slave outputs change on the falling edge only
	always @(negedge i_clk)
	begin
		cycle = cycle + 1;
		o_ack = 1'b0;
		o_err = 1'b0;
		if (!i_cyc)
		begin
			// Dropped cycle cancels everything in flight
			ready_q.delete();
			addr_q.delete();
			fail_q.delete();
			strobe_count = 0;
			o_stall      = 1'b0;
		end
		else
		begin
			// At most one response per cycle, head of line only
			if (ready_q.size() > 0 && ready_q[0] <= cycle)
			begin
				if (fail_q[0])
					o_err = 1'b1;
				else
				begin
					o_ack  = 1'b1;
					o_data = word_at(addr_q[0]);
				end
				void'(ready_q.pop_front());
				void'(addr_q.pop_front());
				void'(fail_q.pop_front());
			end
			o_stall = (($random(seed) & 3) == 0);
			// Strobe taken at the coming rising edge
			if (i_stb && !o_stall)
			begin
				ready_q.push_back(cycle + 1 + ($random(seed) & 3));
				addr_q.push_back(i_addr);
				fail_q.push_back(strobe_count == i_err_index);
				strobe_count = strobe_count + 1;
			end
		end
	end

endmodule

// ==== tests/tb_mm2s.sv ====
// Testbench top for the DMA reader with trace stimulus, bus and stream checks, timeout
module tb_mm2s
	import mm2s_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int AW       = 16;
	localparam int LGL      = 8;
	localparam int MAX_XFER = 64;

	logic                   i_clk;
	logic                   i_reset;
	logic                   i_request;
	xfer_size_e             i_size;
	logic [AW-1:0]          i_addr;
	logic [LGL:0]           i_transferlen;
	logic                   o_busy;
	logic                   o_err;
	logic                   o_rd_cyc;
	logic                   o_rd_stb;
	logic [AW-WBLSB-1:0]    o_rd_addr;
	logic [BUS_BYTES-1:0]   o_rd_sel;
	logic                   i_rd_stall;
	logic                   i_rd_ack;
	logic [8*BUS_BYTES-1:0] i_rd_data;
	logic                   i_rd_err;
	logic                   o_m_valid;
	logic [8*BUS_BYTES-1:0] o_m_data;
	logic [WBLSB:0]         o_m_bytes;
	logic                   o_m_last;

	// Trace contents
	xfer_size_e   t_size[MAX_XFER];
	logic [AW-1:0] t_addr[MAX_XFER];
	logic [LGL:0] t_len[MAX_XFER];
	int           t_err[MAX_XFER];
	int           n_xfer;

	// Monitor state of the running transfer
	string        test_name;
	bit           monitor_on;
	logic [7:0]   got_q[$];
	int           last_count;
	bit           after_last;
	xfer_size_e   cur_size;
	logic [AW-1:0] cur_addr;
	logic [LGL:0] cur_len;
	int           err_index;
	int           cycles;
	int           cycle_limit;

	mm2s_top #(
		.ADDRESS_WIDTH(AW),
		.LGLENGTH(LGL)
	) uut (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_size(i_size),
		.i_addr(i_addr),
		.i_transferlen(i_transferlen),
		.o_busy(o_busy),
		.o_err(o_err),
		.o_rd_cyc(o_rd_cyc),
		.o_rd_stb(o_rd_stb),
		.o_rd_addr(o_rd_addr),
		.o_rd_sel(o_rd_sel),
		.i_rd_stall(i_rd_stall),
		.i_rd_ack(i_rd_ack),
		.i_rd_data(i_rd_data),
		.i_rd_err(i_rd_err),
		.o_m_valid(o_m_valid),
		.o_m_data(o_m_data),
		.o_m_bytes(o_m_bytes),
		.o_m_last(o_m_last)
	);

	mm2s_mem_model #(
		.ADDRESS_WIDTH(AW)
	) u_mem (
		.i_clk(i_clk),
		.i_cyc(o_rd_cyc),
		.i_stb(o_rd_stb),
		.i_addr(o_rd_addr),
		.i_err_index(err_index),
		.o_stall(i_rd_stall),
		.o_ack(i_rd_ack),
		.o_err(i_rd_err),
		.o_data(i_rd_data)
	);

	// 40 ns clock
	always #20 i_clk = ~i_clk;

	////////////////////////////////////////////////////////////////////////////
	// Error reporting and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic byte_equal(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act)
			stop_run($sformatf("CHECK FAILED %s expected %02h actual %02h", name, exp, act));
	endtask

	task automatic count_equal(input string name, input logic [LGL:0] exp,
		input logic [LGL:0] act);
		if (exp !== act)
			stop_run($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic flag_equal(input string name, input logic exp, input logic act);
		if (exp !== act)
			stop_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
	endtask

	// Memory byte, the whole address folded into eight bits XOR 5a
	function automatic logic [7:0] pattern_byte(input logic [AW-1:0] addr);
		logic [7:0] value;
		value = 8'h5a;
		for (int b = 0; b < AW; b += 8)
			value = value ^ 8'(addr >> b);
		return value;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bus and stream monitor
	////////////////////////////////////////////////////////////////////////////

	// Values read here are the ones the DUT sees at this edge
	always @(posedge i_clk)
	begin : monitor
		int a;
		int lo;
		int hi;
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit)
			stop_run("Timeout: the transfers did not finish within the cycle limit");
		if (monitor_on && o_rd_stb && !i_rd_stall)
		begin
			flag_equal({test_name, " select non-empty"}, 1'b1, o_rd_sel != '0);
			if (cur_size == SZ_BYTE)
				flag_equal({test_name, " byte select"}, 1'b1, $countones(o_rd_sel) == 1);
			// Lanes of one aligned half only
			if (cur_size == SZ_HALF)
				flag_equal({test_name, " half select"}, 1'b1,
					(o_rd_sel & 4'b0011) == '0 || (o_rd_sel & 4'b1100) == '0);
			lo = int'(cur_addr);
			hi = lo + int'(cur_len);
			for (int k = 0; k < BUS_BYTES; k++)
			begin
				a = int'({o_rd_addr, WBLSB'(0)}) + k;
				if (o_rd_sel[BUS_BYTES-1-k])
					flag_equal({test_name, " address in range"}, 1'b1, a >= lo && a < hi);
			end
		end
		// Transfer ends the cycle after its last beat
		if (monitor_on && after_last)
			flag_equal({test_name, " busy after last beat"}, 1'b0, o_busy);
		if (monitor_on && o_m_valid)
		begin
			if (after_last)
				stop_run({test_name, ": a stream beat came after the last beat"});
			flag_equal({test_name, " beat bytes 1 to 4"}, 1'b1,
				o_m_bytes >= 1 && o_m_bytes <= BUS_BYTES);
			for (int k = 0; k < int'(o_m_bytes); k++)
				got_q.push_back(o_m_data[8*(BUS_BYTES-1-k) +: 8]);
			if (o_m_last)
			begin
				last_count = last_count + 1;
				after_last = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic load_trace();
		int    fd;
		int    rc;
		int    sz;
		int    ad;
		int    ln;
		int    ei;
		string line;
		fd = $fopen("tests/mm2s_trace.txt", "r");
		if (fd == 0)
			stop_run("Could not open the trace file tests/mm2s_trace.txt");
		n_xfer = 0;
		while (!$feof(fd))
		begin
			line = "";
			rc = $fgets(line, fd);
			if (line.len() > 1 && line[0] != 8'h23)
			begin
				rc = $sscanf(line, "%d %h %d %d", sz, ad, ln, ei);
				if (rc != 4 || n_xfer >= MAX_XFER)
					stop_run({"Malformed or oversized trace at line: ", line});
				t_size[n_xfer] = xfer_size_e'(2'(sz));
				t_addr[n_xfer] = AW'(ad);
				t_len[n_xfer]  = (LGL+1)'(ln);
				t_err[n_xfer]  = ei;
				n_xfer = n_xfer + 1;
			end
		end
		$fclose(fd);
	endtask

	// One transfer from request to idle, then result checks
	task automatic run_transfer(input int idx);
		logic [7:0] exp;
		test_name  = $sformatf("xfer %0d", idx);
		cur_size   = t_size[idx];
		cur_addr   = t_addr[idx];
		cur_len    = t_len[idx];
		err_index  = t_err[idx];
		got_q.delete();
		last_count = 0;
		after_last = 1'b0;
		@(negedge i_clk);
		i_request     = 1'b1;
		i_size        = cur_size;
		i_addr        = cur_addr;
		i_transferlen = cur_len;
		while (!o_busy)
			@(negedge i_clk);
		i_request = 1'b0;
		flag_equal({test_name, " error cleared by request"}, 1'b0, o_err);
		while (o_busy)
			@(negedge i_clk);
		flag_equal({test_name, " cycle dropped"}, 1'b0, o_rd_cyc);
		if (err_index >= 0)
			flag_equal({test_name, " error level"}, 1'b1, o_err);
		else
		begin
			flag_equal({test_name, " error level"}, 1'b0, o_err);
			count_equal({test_name, " last beats"}, (LGL+1)'(1), (LGL+1)'(last_count));
			count_equal({test_name, " byte total"}, cur_len, (LGL+1)'(got_q.size()));
			for (int j = 0; j < int'(cur_len); j++)
			begin
				exp = pattern_byte(cur_addr + AW'(j));
				byte_equal($sformatf("%s byte %0d", test_name, j), exp, got_q[j]);
			end
		end
		repeat (2) @(negedge i_clk);
	endtask

	initial
	begin
		i_clk         = 1'b0;
		i_reset       = 1'b1;
		i_request     = 1'b0;
		i_size        = SZ_WORD;
		i_addr        = '0;
		i_transferlen = '0;
		err_index     = -1;
		monitor_on    = 1'b0;
		cycles        = 0;
		cycle_limit   = 0;
		load_trace();
		// 64 cycles per byte plus room for reset and idle gaps
		cycle_limit = 500;
		for (int i = 0; i < n_xfer; i++)
			cycle_limit = cycle_limit + 64 * int'(t_len[i]);
		repeat (8) @(negedge i_clk);
		i_reset = 1'b0;
		@(negedge i_clk);
		flag_equal("reset busy", 1'b0, o_busy);
		flag_equal("reset err", 1'b0, o_err);
		flag_equal("reset cyc", 1'b0, o_rd_cyc);
		flag_equal("reset stb", 1'b0, o_rd_stb);
		flag_equal("reset valid", 1'b0, o_m_valid);
		monitor_on = 1'b1;
		for (int i = 0; i < n_xfer; i++)
			run_transfer(i);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== sim.f ====
hw/mm2s_pkg.sv
hw/mm2s_request_decode.sv
hw/mm2s_bus_reader.sv
hw/mm2s_stream_packer.sv
hw/mm2s_top.sv
tests/mm2s_mem_model.sv
tests/tb_mm2s.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_mm2s -o vsim_mm2s

./obj_dir/vsim_mm2s > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// ==== tests/mm2s_trace.txt ====
# size code (0 word, 1 word, 2 half, 3 byte), start address (hex), length (dec)
# last column is the strobe index that gets a bus error, -1 for none
0 0100 16 -1
0 0203 13 -1
2 0301 9 -1
3 0405 5 -1
0 0506 1 -1
1 0610 12 -1
2 0700 20 2
0 0800 8 -1
0 0902 40 3
3 0a00 6 -1
2 0b02 2 -1
0 0c01 3 -1
3 0d07 1 -1
0 0e00 64 -1
2 0f03 17 0
3 1000 4 -1
2 1101 1 -1
0 1203 30 -1
